//--- logic/opc_defs.svh
`ifndef OPC_DEFS_SVH
`define OPC_DEFS_SVH

// data and address word width.
`define OPC_WORD_W 16

// memory address bits, upper bits of the bus address are ignored.
`define OPC_MEM_AW 12

// number of general registers.
`define OPC_REGS 16

// store here to report a result.
`define OPC_OUT_ADDR 16'hFF00

`endif

//--- logic/opc_isa_pkg.sv
package opc_isa_pkg;

   `include "opc_defs.svh"

   typedef logic [`OPC_WORD_W-1:0] word_t;
   typedef logic [3:0]             reg_idx_t;

   // instruction word fields.
   localparam int bit_pred_c   = 15;
   localparam int bit_pred_nz  = 14;
   localparam int bit_indirect = 12;
   localparam int bit_op_hi    = 11;
   localparam int bit_op_lo    = 10;
   localparam int bit_src_hi   = 7;
   localparam int bit_src_lo   = 4;
   localparam int bit_dst_hi   = 3;
   localparam int bit_dst_lo   = 0;

   // r0 reads as zero, r15 is the program counter.
   localparam reg_idx_t reg_zero = 4'h0;
   localparam reg_idx_t reg_pc   = 4'hF;

   typedef enum logic [1:0] {
      op_ld   = 2'b00,
      op_add  = 2'b01,
      op_nand = 2'b10,
      op_sto  = 2'b11
   } op_e;

   typedef enum logic [2:0] {
      st_fetch0 = 3'h0,
      st_fetch1 = 3'h1,
      st_ea_ed  = 3'h2,
      st_rdmem  = 3'h3,
      st_exec   = 3'h4,
      st_wrmem  = 3'h5
   } cpu_state_e;

endpackage

//--- logic/opc_bus_pkg.sv
package opc_bus_pkg;

   // single-cycle bus from the core, no wait states.
   typedef struct packed {
      opc_isa_pkg::word_t addr;
      opc_isa_pkg::word_t wdata;
      logic               we;
   } bus_t;

   // program image load, one word per cycle while en is high.
   typedef struct packed {
      logic               en;
      opc_isa_pkg::word_t addr;
      opc_isa_pkg::word_t data;
   } load_t;

endpackage

//--- logic/opc_regfile.sv
`timescale 1ns/10ps

`include "opc_defs.svh"

module opc_regfile (
   input  logic                  clk,
   input  opc_isa_pkg::reg_idx_t rd_idx,
   input  opc_isa_pkg::word_t    pc,
   output opc_isa_pkg::word_t    rd_data,
   input  logic                  wr_en,
   input  opc_isa_pkg::reg_idx_t wr_idx,
   input  opc_isa_pkg::word_t    wr_data
);
   import opc_isa_pkg::*;

   word_t regs [`OPC_REGS];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         regs[wr_idx] <= wr_data;
   end

   // slots 0 and 15 are written but never read back.
   always_comb
   begin
      if (rd_idx == reg_zero)
         rd_data = '0;
      else if (rd_idx == reg_pc)
         rd_data = pc;
      else
         rd_data = regs[rd_idx];
   end

endmodule

//--- logic/opc_cpu.sv
`timescale 1ns/10ps

module opc_cpu (
   input  logic               clk,
   input  logic               reset_b,
   output opc_bus_pkg::bus_t  bus,
   input  opc_isa_pkg::word_t rdata
);
   import opc_isa_pkg::*;

   cpu_state_e state;
   word_t      ir;
   word_t      opnd;
   word_t      pc;
   word_t      src_val;
   word_t      result;
   logic       carry_q;
   logic       zero_q;
   logic       carry_d;
   logic       pred_ok;
   logic       rf_wr_en;
   op_e        op;
   reg_idx_t   src_idx;
   reg_idx_t   dst_idx;

   assign op      = op_e'(ir[bit_op_hi:bit_op_lo]);
   assign src_idx = ir[bit_src_hi:bit_src_lo];
   assign dst_idx = ir[bit_dst_hi:bit_dst_lo];

   // a set predicate bit demands its flag condition.
   assign pred_ok = (!ir[bit_pred_c] || carry_q) && (!ir[bit_pred_nz] || !zero_q);

   assign rf_wr_en = (state == st_exec);

   opc_regfile u_regfile (
      .clk     (clk),
      .rd_idx  (src_idx),
      .pc      (pc),
      .rd_data (src_val),
      .wr_en   (rf_wr_en),
      .wr_idx  (dst_idx),
      .wr_data (result)
   );

   // alu, carry held unless add.
   always_comb
   begin
      result  = opnd;
      carry_d = carry_q;
      case (op)
         op_add:
            {carry_d, result} = {1'b0, src_val} + {1'b0, opnd};
         op_nand:
            result = ~(src_val & opnd);
         default:
            result = opnd;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= st_fetch0;
      else
      begin
         case (state)
            st_fetch0:
               state <= st_fetch1;
            st_fetch1:
               state <= pred_ok ? st_ea_ed : st_fetch0;
            st_ea_ed:
            begin
               if (ir[bit_indirect])
                  state <= st_rdmem;
               else if (op == op_sto)
                  state <= st_wrmem;
               else
                  state <= st_exec;
            end
            st_rdmem:
               state <= st_exec;
            default:
               state <= st_fetch0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == st_fetch0)
         ir <= rdata;
   end

   // operand, then effective address, then memory data if indirect.
   always_ff @(posedge clk)
   begin
      case (state)
         st_fetch1, st_rdmem:
            opnd <= rdata;
         st_ea_ed:
            opnd <= src_val + opnd;
         default:
            opnd <= opnd;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc <= '0;
      else if (state == st_fetch0 || state == st_fetch1)
         pc <= pc + 1'b1;
      else if (state == st_exec && dst_idx == reg_pc)
         pc <= result;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         carry_q <= 1'b0;
         zero_q  <= 1'b0;
      end
      else if (state == st_exec)
      begin
         carry_q <= carry_d;
         zero_q  <= (result == '0);
      end
   end

   always_comb
   begin
      bus.addr  = (state == st_wrmem || state == st_rdmem) ? opnd : pc;
      bus.wdata = src_val;
      bus.we    = (state == st_wrmem);
   end

   a_state_legal: assert property (@(posedge clk) disable iff (!reset_b)
      state inside {st_fetch0, st_fetch1, st_ea_ed, st_rdmem, st_exec, st_wrmem});

   // a write cycle is always entered straight from address formation.
   a_we_wrmem: assert property (@(posedge clk) disable iff (!reset_b)
      bus.we |-> (state == st_wrmem) && ($past(state) == st_ea_ed));

endmodule

//--- logic/opc_mem.sv
`timescale 1ns/10ps

`include "opc_defs.svh"

module opc_mem (
   input  logic               clk,
   input  opc_bus_pkg::bus_t  bus,
   input  opc_bus_pkg::load_t load,
   output opc_isa_pkg::word_t rdata
);
   import opc_isa_pkg::*;

   word_t                  mem [1 << `OPC_MEM_AW];
   logic [`OPC_MEM_AW-1:0] wr_addr;
   word_t                  wr_data;
   logic                   wr_en;

   // load port wins, it is only used with the core in reset.
   always_comb
   begin
      if (load.en)
      begin
         wr_addr = load.addr[`OPC_MEM_AW-1:0];
         wr_data = load.data;
      end
      else
      begin
         wr_addr = bus.addr[`OPC_MEM_AW-1:0];
         wr_data = bus.wdata;
      end
      wr_en = load.en || bus.we;
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   assign rdata = mem[bus.addr[`OPC_MEM_AW-1:0]];

   // core must be held in reset while loading.
   a_load_excl: assert property (@(posedge clk) load.en |-> !bus.we);

endmodule

//--- logic/opc_out_port.sv
`timescale 1ns/10ps

`include "opc_defs.svh"

module opc_out_port (
   input  logic               clk,
   input  logic               reset_b,
   input  opc_bus_pkg::bus_t  bus,
   output opc_isa_pkg::word_t out_data,
   output logic               out_valid
);
   logic hit;

   assign hit = bus.we && (bus.addr == `OPC_OUT_ADDR);

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         out_valid <= 1'b0;
      else
         out_valid <= hit;
   end

   always_ff @(posedge clk)
   begin
      if (hit)
         out_data <= bus.wdata;
   end

   // stores from the core are at least four cycles apart.
   a_single_pulse: assert property (@(posedge clk) disable iff (!reset_b)
      out_valid |=> !out_valid);

endmodule

//--- logic/opc_system.sv
`timescale 1ns/10ps

module opc_system (
   input  logic               clk,
   input  logic               reset_b,
   input  opc_bus_pkg::load_t load,
   output opc_isa_pkg::word_t out_data,
   output logic               out_valid
);
   import opc_isa_pkg::*;
   import opc_bus_pkg::*;

   bus_t  cpu_bus;
   word_t mem_rdata;

   opc_cpu u_cpu (
      .clk     (clk),
      .reset_b (reset_b),
      .bus     (cpu_bus),
      .rdata   (mem_rdata)
   );

   // also receives output port stores, see aliasing at word f00.
   opc_mem u_mem (
      .clk   (clk),
      .bus   (cpu_bus),
      .load  (load),
      .rdata (mem_rdata)
   );

   opc_out_port u_out_port (
      .clk       (clk),
      .reset_b   (reset_b),
      .bus       (cpu_bus),
      .out_data  (out_data),
      .out_valid (out_valid)
   );

endmodule

//--- testbench/opc_tb.sv
`timescale 1ns/10ps

`include "opc_defs.svh"

module opc_tb;
   import opc_isa_pkg::*;
   import opc_bus_pkg::*;

   localparam int    mem_words   = 1 << `OPC_MEM_AW;
   localparam word_t data_base   = 16'h0800;
   localparam word_t scratch     = 16'h0900;
   localparam int    idle_cycles = 24;

   logic  clk;
   logic  reset_b;
   load_t load;
   word_t out_data;
   logic  out_valid;

   word_t  image [mem_words];
   word_t  ref_mem [mem_words];
   bit     out_sto [mem_words];
   word_t  exp_q [$];
   int     prog_len;
   int     n_instr;
   int     n_expected;
   int     n_seen = 0;
   int     error_count = 0;
   int     cycle_count = 0;
   int     cycle_limit = 0;
   integer seed;

   opc_system dut0 (
      .clk       (clk),
      .reset_b   (reset_b),
      .load      (load),
      .out_data  (out_data),
      .out_valid (out_valid)
   );

   always #4 clk = ~clk;

   task automatic compare_word(input string name, input word_t actual, input word_t expected);
      if (actual !== expected)
      begin
         error_count++;
         $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic word_t encode(input logic c_pred, input logic nz_pred, input logic ind,
                                    input op_e op, input reg_idx_t src, input reg_idx_t dst);
      word_t w;
      w = '0;
      w[bit_pred_c]            = c_pred;
      w[bit_pred_nz]           = nz_pred;
      w[bit_indirect]          = ind;
      w[bit_op_hi:bit_op_lo]   = op;
      w[bit_src_hi:bit_src_lo] = src;
      w[bit_dst_hi:bit_dst_lo] = dst;
      return w;
   endfunction

   task automatic emit(input word_t instr, input word_t operand, input bit to_out);
      image[prog_len]     = instr;
      image[prog_len + 1] = operand;
      out_sto[prog_len]   = to_out;
      prog_len += 2;
   endtask

   // operand is filled in by the model, so the store lands on the output port.
   task automatic emit_out(input logic c_pred, input logic nz_pred, input reg_idx_t src);
      emit(encode(c_pred, nz_pred, 1'b0, op_sto, src, 4'h0), '0, 1'b1);
   endtask

   task automatic build_program();
      word_t a;
      word_t b;
      word_t g;
      int    i;
      for (i = 0; i < mem_words; i++)
      begin
         image[i]   = '0;
         out_sto[i] = 1'b0;
      end
      prog_len = 0;
      a = $random(seed);
      b = $random(seed);
      g = $random(seed);
      image[data_base]     = $random(seed);
      image[data_base + 1] = $random(seed);
      // alu with random operands.
      emit(encode(0, 0, 0, op_ld, 4'h0, 4'h1), a, 0);
      emit(encode(0, 0, 0, op_ld, 4'h0, 4'h2), b, 0);
      emit_out(0, 0, 4'h1);
      emit(encode(0, 0, 0, op_add, 4'h1, 4'h3), b, 0);
      emit_out(0, 0, 4'h3);
      emit(encode(0, 0, 0, op_nand, 4'h2, 4'h4), a, 0);
      emit_out(0, 0, 4'h4);
      emit_out(1, 0, 4'h3);
      // ffff + 2 sets carry only, ffff + 1 sets carry and zero, 0 + 1 clears both.
      emit(encode(0, 0, 0, op_ld, 4'h0, 4'h5), 16'hFFFF, 0);
      emit(encode(0, 0, 0, op_add, 4'h5, 4'h6), 16'h0002, 0);
      emit_out(0, 1, 4'h1);
      emit_out(1, 0, 4'h1);
      emit(encode(0, 0, 0, op_add, 4'h5, 4'h6), 16'h0001, 0);
      emit_out(1, 0, 4'h2);
      emit_out(0, 1, 4'h2);
      emit_out(1, 1, 4'h6);
      emit(encode(0, 0, 0, op_add, 4'h0, 4'h7), 16'h0001, 0);
      emit_out(1, 0, 4'h7);
      emit_out(0, 1, 4'h7);
      // store then read back, and indirect reads of data words.
      emit(encode(0, 0, 0, op_sto, 4'h2, 4'h0), scratch - b, 0);
      emit(encode(0, 0, 1, op_ld, 4'h0, 4'h8), scratch, 0);
      emit_out(0, 0, 4'h8);
      emit(encode(0, 0, 1, op_ld, 4'h0, 4'h9), data_base, 0);
      emit_out(0, 0, 4'h9);
      emit(encode(0, 0, 1, op_add, 4'h1, 4'hA), data_base + 1 - a, 0);
      emit_out(0, 0, 4'hA);
      // jump over a store of r0.
      emit(encode(0, 0, 0, op_ld, 4'h0, 4'hF), word_t'(prog_len + 4), 0);
      emit(encode(0, 0, 0, op_sto, 4'h0, 4'h0), `OPC_OUT_ADDR, 0);
      emit(encode(0, 0, 0, op_add, 4'h0, 4'hB), g, 0);
      emit_out(0, 0, 4'hB);
      emit(encode(0, 0, 0, op_nand, 4'h0, 4'hC), g, 0);
      emit_out(0, 0, 4'hC);
      emit(encode(0, 0, 0, op_ld, 4'h0, 4'hF), word_t'(prog_len), 0);
   endtask

   // instruction-level model, returns the number of instructions run.
   function automatic int run_model();
      word_t    regs [16];
      word_t    pc;
      word_t    here;
      word_t    instr;
      word_t    operand;
      word_t    eff;
      word_t    res;
      logic     carry;
      logic     zero;
      logic     done;
      reg_idx_t s;
      reg_idx_t d;
      op_e      op;
      int       count;
      int       i;
      for (i = 0; i < mem_words; i++)
         ref_mem[i] = image[i];
      for (i = 0; i < 16; i++)
         regs[i] = '0;
      pc    = '0;
      carry = 1'b0;
      zero  = 1'b0;
      done  = 1'b0;
      count = 0;
      while (!done && count < 1000)
      begin
         here     = pc;
         instr    = ref_mem[here[11:0]];
         operand  = ref_mem[here[11:0] + 12'd1];
         s        = instr[bit_src_hi:bit_src_lo];
         d        = instr[bit_dst_hi:bit_dst_lo];
         op       = op_e'(instr[bit_op_hi:bit_op_lo]);
         pc       = here + 16'd2;
         regs[0]  = '0;
         regs[15] = pc;
         if (out_sto[here[11:0]])
         begin
            operand = `OPC_OUT_ADDR - regs[s];
            ref_mem[here[11:0] + 12'd1] = operand;
            image[here[11:0] + 12'd1]   = operand;
         end
         count++;
         if ((!instr[bit_pred_c] || carry) && (!instr[bit_pred_nz] || !zero))
         begin
            eff = regs[s] + operand;
            if (op == op_sto && !instr[bit_indirect])
            begin
               ref_mem[eff[11:0]] = regs[s];
               if (eff == `OPC_OUT_ADDR)
                  exp_q.push_back(regs[s]);
            end
            else
            begin
               if (instr[bit_indirect])
                  eff = ref_mem[eff[11:0]];
               case (op)
                  op_add:
                     {carry, res} = {1'b0, regs[s]} + {1'b0, eff};
                  op_nand:
                     res = ~(regs[s] & eff);
                  default:
                     res = eff;
               endcase
               zero = (res == '0);
               if (d == reg_pc)
               begin
                  done = (res == here);
                  pc   = res;
               end
               else
                  regs[d] = res;
            end
         end
      end
      return count;
   endfunction

   task automatic load_word(input word_t addr, input word_t data);
      @(posedge clk);
      load.en   <= 1'b1;
      load.addr <= addr;
      load.data <= data;
   endtask

   always @(posedge clk)
   begin
      if (out_valid !== 1'b0)
      begin
         compare_word("out_valid", word_t'(out_valid), 16'h0001);
         if (n_seen >= n_expected)
         begin
            $display("an output word %h appeared after all expected words", out_data);
            $display("Finished with errors");
            $fatal(1, "unexpected output");
         end
         compare_word("out_data", out_data, exp_q[n_seen]);
         n_seen <= n_seen + 1;
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count > cycle_limit)
      begin
         $display("timed out after %0d cycles with %0d of %0d output words seen",
                  cycle_count, n_seen, n_expected);
         $display("Finished with errors");
         $fatal(1, "timeout");
      end
   end

   initial
   begin
      int i;
      clk     = 1'b0;
      reset_b = 1'b0;
      load    = '0;
      seed    = 49194;
      build_program();
      n_instr     = run_model();
      n_expected  = exp_q.size();
      cycle_limit = prog_len + 2 + 10 + 5 * n_instr + idle_cycles + 50;
      // core held in reset for the whole load.
      for (i = 0; i < prog_len; i++)
         load_word(word_t'(i), image[i]);
      load_word(data_base, image[data_base]);
      load_word(data_base + 1, image[data_base + 1]);
      @(posedge clk);
      load.en <= 1'b0;
      repeat (10)
      begin
         @(posedge clk);
         compare_word("out_valid", word_t'(out_valid), 16'h0000);
      end
      reset_b <= 1'b1;
      while (n_seen < n_expected)
         @(posedge clk);
      // the program now spins on its last jump.
      repeat (idle_cycles)
         @(posedge clk);
      if (error_count == 0)
      begin
         $display("Finished with no errors");
         $finish;
      end
      else
      begin
         $display("Finished with errors");
         $fatal(1, "checks failed");
      end
   end

endmodule

//--- all.f
+incdir+logic
logic/opc_isa_pkg.sv
logic/opc_bus_pkg.sv
logic/opc_regfile.sv
logic/opc_cpu.sv
logic/opc_mem.sv
logic/opc_out_port.sv
logic/opc_system.sv
testbench/opc_tb.sv

//--- Bender.yml
package:
  name: opc_system

sources:
  - include_dirs:
      - logic
    files:
      - logic/opc_isa_pkg.sv
      - logic/opc_bus_pkg.sv
      - logic/opc_regfile.sv
      - logic/opc_cpu.sv
      - logic/opc_mem.sv
      - logic/opc_out_port.sv
      - logic/opc_system.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/opc_tb.sv
